// File: common/umi_apb_defs.svh
// Width, address group, timeout and register count macros, included by the package and by RTL
`ifndef UMI_APB_DEFS_SVH
`define UMI_APB_DEFS_SVH

// ########################################
// Bus widths
// ########################################
`define UMI_AW 64                  // UMI address width
`define UMI_DW 64                  // UMI data width
`define APB_RW 32                  // APB register width
`define APB_RAW 16                 // APB address width

// ########################################
// Address group check
// ########################################
`define UMI_APB_GRPOFFSET 24       // Group field LSB in dstaddr
`define UMI_APB_GRPAW 8            // Group field width, 0 turns the check off
`define UMI_APB_GRPID 8'h5A        // Group this bridge answers to

// ########################################
// Bridge and target limits
// ########################################
`define UMI_APB_TIMEOUT 8          // Access cycles before abort

`define APB_NREGS 16               // Target register count

`endif

// File: common/umi_apb_pkg.sv
// Shared UMI packet and APB bus types, referenced by scoped name from every bridge block
`include "umi_apb_defs.svh"

package umi_apb_pkg;

   // ########################################
   // UMI command word
   // ########################################
   typedef enum logic [4:0] {
      INVALID    = 5'd0,
      REQ_READ   = 5'd1,
      RESP_READ  = 5'd2,
      REQ_WRITE  = 5'd3,
      RESP_WRITE = 5'd4,
      REQ_POSTED = 5'd5,
      REQ_RDMA   = 5'd7,
      REQ_ATOMIC = 5'd9
   } umi_opcode_e;

   // Listed MSB first, opcode sits in bits 4:0
   typedef struct packed {
      logic [4:0]  hostid;
      logic [1:0]  user_err;       // User bits on request, error on response
      logic        ex;
      logic        eof;
      logic        eom;
      logic [1:0]  prot;
      logic [3:0]  qos;
      logic [7:0]  len;            // Echoed only
      logic [2:0]  size;           // Echoed only
      umi_opcode_e opcode;
   } umi_cmd_t;

   typedef struct packed {
      umi_cmd_t            cmd;
      logic [`UMI_AW-1:0]  dstaddr;
      logic [`UMI_AW-1:0]  srcaddr;
      logic [`UMI_DW-1:0]  data;
   } umi_pkt_t;

   // What the bridge does with a request
   typedef enum logic [1:0] {ACC_DROP, ACC_READ, ACC_WRITE, ACC_POSTED} umi_access_e;

   // Response error codes
   localparam logic [1:0] UMI_ERR_OK      = 2'b00;
   localparam logic [1:0] UMI_ERR_SLV     = 2'b10;   // pslverr from target
   localparam logic [1:0] UMI_ERR_TIMEOUT = 2'b11;   // Access aborted by timer

   // ########################################
   // APB
   // ########################################
   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [`APB_RAW-1:0]   paddr;
      logic [`APB_RW-1:0]    pwdata;
      logic [`APB_RW/8-1:0]  pstrb;
      logic [2:0]            pprot;
   } apb_req_t;

   typedef struct packed {
      logic                pready;
      logic [`APB_RW-1:0]  prdata;
      logic                pslverr;
   } apb_rsp_t;

endpackage

// File: umi2apb/umi2apb_decode.sv
// Combinational request classifier for the bridge, sorts each request into an APB access kind
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module umi2apb_decode (
   input  umi_apb_pkg::umi_pkt_t     req,     // Live request
   output umi_apb_pkg::umi_access_e  kind     // Access class
);

   logic group_match;                         // dstaddr is in our group

   // ########################################
   // Address group
   // ########################################
   generate
      if (`UMI_APB_GRPAW == 0) begin : g_no_group
         assign group_match = 1'b1;           // Check off, accept all
      end else begin : g_group
         localparam logic [`UMI_APB_GRPAW-1:0] grp_id = `UMI_APB_GRPID;
         assign group_match =
            (req.dstaddr[`UMI_APB_GRPOFFSET +: `UMI_APB_GRPAW] == grp_id);
      end
   endgenerate

   // ########################################
   // Opcode map
   // ########################################
   always_comb begin
      kind = umi_apb_pkg::ACC_DROP;           // Miss or unsupported
      if (group_match) begin
         case (req.cmd.opcode)
            umi_apb_pkg::REQ_READ:   kind = umi_apb_pkg::ACC_READ;
            umi_apb_pkg::REQ_WRITE:  kind = umi_apb_pkg::ACC_WRITE;
            umi_apb_pkg::REQ_POSTED: kind = umi_apb_pkg::ACC_POSTED;
            // Atomics, RDMA, invalid and stray responses vanish here
            default:                 kind = umi_apb_pkg::ACC_DROP;
         endcase
      end
   end

endmodule

// File: umi2apb/umi2apb_fsm.sv
// Bridge control FSM, sequences APB setup and access phases and the UMI response handshake
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module umi2apb_fsm (
   input  logic                      clk,
   input  logic                      nreset,
   input  logic                      req_valid,
   input  umi_apb_pkg::umi_access_e  kind,         // From decode, accept cycle only
   input  logic                      pready,
   input  logic                      pslverr,
   input  logic                      expired,      // Timer hit the limit
   input  logic                      resp_ready,
   output logic                      req_ready,
   output logic                      psel,
   output logic                      penable,
   output logic                      capture,      // Latch request
   output logic                      done,         // Latch result
   output logic [1:0]                err_sel,
   output logic                      timer_run,
   output logic                      resp_valid
);

   typedef enum logic [1:0] {IDLE, ACCESS, RESP} state_e;

   state_e state_q;
   state_e state_d;
   logic   posted_q;                               // Current access needs no response

   // ########################################
   // Outputs
   // ########################################
   assign req_ready  = (state_q == IDLE);          // One transaction in flight
   assign capture    = req_ready & req_valid & (kind != umi_apb_pkg::ACC_DROP);
   assign penable    = (state_q == ACCESS);
   assign psel       = capture | penable;          // Setup phase is the accept cycle
   assign timer_run  = penable;
   assign done       = penable & (pready | expired); // pready wins a tie
   assign resp_valid = (state_q == RESP);
   assign err_sel    = !pready ? umi_apb_pkg::UMI_ERR_TIMEOUT :
                       pslverr ? umi_apb_pkg::UMI_ERR_SLV : umi_apb_pkg::UMI_ERR_OK;

   // ########################################
   // State
   // ########################################
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (capture)
               state_d = ACCESS;
         end
         ACCESS: begin
            if (done)
               state_d = posted_q ? IDLE : RESP;   // Posted write ends here
         end
         RESP: begin
            if (resp_ready)
               state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state_q  <= IDLE;
         posted_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (capture)
            posted_q <= (kind == umi_apb_pkg::ACC_POSTED);
      end
   end

   // Timer must cut every access phase short
   assert property (@(posedge clk) disable iff (!nreset)
                    penable |-> ##[0:`UMI_APB_TIMEOUT-1] done)
      else $error("access phase ran past the timeout");

   assert property (@(posedge clk) disable iff (!nreset) pready |-> penable)
      else $error("pready outside the access phase");

endmodule

// File: umi2apb/umi2apb_timer.sv
// Access phase watchdog for the bridge, flags an APB access that has waited too long
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module umi2apb_timer (
   input  logic clk,
   input  logic nreset,
   input  logic run,        // High through the access phase
   output logic expired     // Held until run drops
);

   // Count holds cycles already spent, so the limit is one less
   localparam int limit = `UMI_APB_TIMEOUT - 1;
   localparam int cw    = $clog2(`UMI_APB_TIMEOUT + 1);

   logic [cw-1:0] count_q;

   // ########################################
   // Saturating counter
   // ########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         count_q <= '0;
      end else if (!run) begin
         count_q <= '0;                            // Idle or setup, restart
      end else if (count_q != cw'(limit)) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Rises in access cycle UMI_APB_TIMEOUT
   assign expired = run & (count_q == cw'(limit));

endmodule

// File: umi2apb/umi2apb_datapath.sv
// Bridge datapath, holds the request, feeds APB address and data and assembles the response
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module umi2apb_datapath (
   input  logic                   clk,
   input  logic                   nreset,
   input  umi_apb_pkg::umi_pkt_t  req,            // Live request
   input  logic                   capture,        // Accept strobe
   input  logic                   done,           // Completion strobe
   input  logic [1:0]             err_code,
   input  logic [`APB_RW-1:0]     prdata,
   output umi_apb_pkg::apb_req_t  apb_addr_data,  // psel, penable left 0
   output umi_apb_pkg::umi_pkt_t  resp
);

   umi_apb_pkg::umi_pkt_t  req_q;                  // Held request
   umi_apb_pkg::umi_pkt_t  src;                    // Source of APB fields
   umi_apb_pkg::umi_cmd_t  resp_cmd;
   logic [`APB_RW-1:0]     rdata_q;
   logic [1:0]             err_q;
   logic                   held_read;

   // ########################################
   // Request side
   // ########################################
   always_ff @(posedge clk) begin
      if (capture)
         req_q <= req;
   end

   assign src       = capture ? req : req_q;       // Live in setup cycle
   assign held_read = (req_q.cmd.opcode == umi_apb_pkg::REQ_READ);

   always_comb begin
      apb_addr_data        = '0;
      apb_addr_data.pwrite = (src.cmd.opcode == umi_apb_pkg::REQ_WRITE) |
                             (src.cmd.opcode == umi_apb_pkg::REQ_POSTED);
      apb_addr_data.paddr  = src.dstaddr[`APB_RAW-1:0];
      apb_addr_data.pwdata = src.data[`APB_RW-1:0];
      apb_addr_data.pstrb  = '1;                   // Full register only
      apb_addr_data.pprot  = {1'b0, src.cmd.prot};
   end

   // ########################################
   // Response side
   // ########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rdata_q <= '0;
         err_q   <= umi_apb_pkg::UMI_ERR_OK;
      end else if (done) begin
         err_q   <= err_code;
         // Writes and aborted reads return zero
         rdata_q <= (held_read && err_code != umi_apb_pkg::UMI_ERR_TIMEOUT) ? prdata : '0;
      end
   end

   always_comb begin
      resp_cmd          = req_q.cmd;               // size, len and the rest echo
      resp_cmd.opcode   = held_read ? umi_apb_pkg::RESP_READ : umi_apb_pkg::RESP_WRITE;
      resp_cmd.user_err = err_q;
   end

   always_comb begin
      resp.cmd     = resp_cmd;
      resp.dstaddr = req_q.srcaddr;                // Back to the sender
      resp.srcaddr = req_q.dstaddr;
      resp.data    = {{(`UMI_DW - `APB_RW){1'b0}}, rdata_q};
   end

endmodule

// File: design/apb_regfile.sv
// APB register target with programmable wait states, sits behind the bridge as a slow peripheral
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module apb_regfile (
   input  logic                   clk,
   input  logic                   nreset,
   input  umi_apb_pkg::apb_req_t  apb,
   output umi_apb_pkg::apb_rsp_t  apb_rsp
);

   localparam int iw   = $clog2(`APB_NREGS);        // Index bits
   localparam int span = `APB_NREGS * (`APB_RW / 8); // Decoded bytes

   logic [`APB_RW-1:0] regs_q [`APB_NREGS];
   logic [iw-1:0]      idx;
   logic               in_range;
   logic               access;                      // Access phase
   logic               ready;
   logic [3:0]         wait_cfg;                    // W from register 0
   logic [3:0]         wait_q;

   assign idx      = apb.paddr[iw+1:2];             // Word index
   assign in_range = (apb.paddr < `APB_RAW'(span));
   assign access   = apb.psel & apb.penable;
   assign wait_cfg = regs_q[0][3:0];
   assign ready    = access & (wait_q == wait_cfg); // Access cycle W+1

   // ########################################
   // Wait states
   // ########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wait_q <= '0;
      end else if (!access || ready) begin
         wait_q <= '0;                              // Restart each access
      end else begin
         wait_q <= wait_q + 1'b1;
      end
   end

   // ########################################
   // Registers
   // ########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < `APB_NREGS; i++)
            regs_q[i] <= '0;
      end else if (ready && apb.pwrite && in_range) begin
         for (int b = 0; b < `APB_RW / 8; b++) begin
            if (apb.pstrb[b])
               regs_q[idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
         end
      end
   end

   assign apb_rsp.pready  = ready;
   assign apb_rsp.prdata  = in_range ? regs_q[idx] : '0;
   assign apb_rsp.pslverr = access & ~in_range;     // Out of range, no write

   assert property (@(posedge clk) disable iff (!nreset) apb.penable |-> $stable(apb.paddr))
      else $error("paddr changed during access phase");

endmodule

// File: design/umi_apb_top.sv
// Subsystem top, joins the UMI to APB bridge blocks with the APB register target
`timescale 1ns/1ps

module umi_apb_top (
   input  logic                   clk,
   input  logic                   nreset,
   input  umi_apb_pkg::umi_pkt_t  req,
   input  logic                   req_valid,
   output logic                   req_ready,
   output umi_apb_pkg::umi_pkt_t  resp,
   output logic                   resp_valid,
   input  logic                   resp_ready
);

   umi_apb_pkg::umi_access_e kind;
   umi_apb_pkg::apb_req_t    apb_fields;            // From datapath
   umi_apb_pkg::apb_req_t    apb;                   // Full bus to target
   umi_apb_pkg::apb_rsp_t    apb_rsp;
   logic                     psel;
   logic                     penable;
   logic                     capture;
   logic                     done;
   logic                     timer_run;
   logic                     expired;
   logic [1:0]               err_sel;

   // ########################################
   // Bridge
   // ########################################
   umi2apb_decode i_decode (.req(req), .kind(kind));

   umi2apb_fsm i_fsm (
      .clk(clk), .nreset(nreset), .req_valid(req_valid), .kind(kind),
      .pready(apb_rsp.pready), .pslverr(apb_rsp.pslverr), .expired(expired),
      .resp_ready(resp_ready), .req_ready(req_ready), .psel(psel), .penable(penable),
      .capture(capture), .done(done), .err_sel(err_sel), .timer_run(timer_run),
      .resp_valid(resp_valid));

   umi2apb_timer i_timer (.clk(clk), .nreset(nreset), .run(timer_run), .expired(expired));

   umi2apb_datapath i_datapath (
      .clk(clk), .nreset(nreset), .req(req), .capture(capture), .done(done),
      .err_code(err_sel), .prdata(apb_rsp.prdata), .apb_addr_data(apb_fields), .resp(resp));

   // Phase controls from FSM, the rest from datapath
   assign apb = '{psel: psel, penable: penable, pwrite: apb_fields.pwrite,
                  paddr: apb_fields.paddr, pwdata: apb_fields.pwdata,
                  pstrb: apb_fields.pstrb, pprot: apb_fields.pprot};

   // ########################################
   // Target
   // ########################################
   apb_regfile i_regfile (.clk(clk), .nreset(nreset), .apb(apb), .apb_rsp(apb_rsp));

endmodule

// File: test/tb_umi_apb.sv
// Self-checking testbench for the UMI to APB subsystem, run with flist.f and top tb_umi_apb
`timescale 1ns/1ps
`include "umi_apb_defs.svh"

module tb_umi_apb;

   localparam int t1_n = 48;                       // Random reads and writes
   localparam int t2_n = 12;                       // Posted write plus read pairs
   localparam int t3_n = 12;                       // Out of range accesses
   localparam int t4_n = 10;                       // Accesses with W over the limit
   localparam int t5_n = 16;                       // Dropped requests
   localparam int t6_n = 16;                       // Long response holds
   localparam int n_txn = t1_n + 2 * t2_n + t3_n + 4 + t4_n + 6 + 2 * t5_n + t6_n;
   localparam int watchdog_cycles = n_txn * (`UMI_APB_TIMEOUT + 20) + 3 * 16;

   logic                  clk;
   logic                  nreset;
   umi_apb_pkg::umi_pkt_t req;
   logic                  req_valid;
   logic                  req_ready;
   umi_apb_pkg::umi_pkt_t resp;
   logic                  resp_valid;
   logic                  resp_ready;

   logic [31:0] rng_state = 32'h689a_b103;
   logic [31:0] mirror [`APB_NREGS];               // Register model
   logic [3:0]  wait_w;                            // Model of W
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          mark;

   umi_apb_top i_dut (
      .clk(clk), .nreset(nreset), .req(req), .req_valid(req_valid), .req_ready(req_ready),
      .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready));

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                       // 8 ns period
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog fired after %0d cycles, the DUT stopped responding", watchdog_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

   // ########################################
   // Helpers
   // ########################################
   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // LCG step
      return rng_state;
   endfunction

   function automatic logic [31:0] safe_data(input logic [3:0] idx);
      logic [31:0] d;
      d = next_random();
      if (idx == 4'd0)
         d[3] = 1'b0;                              // Keep W below the limit
      return d;
   endfunction

   task automatic advance_cycle();
      @(posedge clk);
      #1;                                          // Drive and sample point
   endtask

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("Test %0d %-22s done with %0d errors", tests, name, errors - mark);
      mark = errors;
   endtask

   task automatic apply_reset();
      req_valid  = 1'b0;
      resp_ready = 1'b0;
      nreset     = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      nreset = 1'b1;
      for (int k = 0; k < `APB_NREGS; k++)
         mirror[k] = '0;
      wait_w = 4'd0;
      compare("req_ready", 64'd1, {63'd0, req_ready});
      compare("resp_valid", 64'd0, {63'd0, resp_valid});
   endtask

   task automatic send_request(input umi_apb_pkg::umi_pkt_t pkt);
      req       = pkt;
      req_valid = 1'b1;
      while (!req_ready)
         advance_cycle();
      advance_cycle();                             // Taken on this edge
      req_valid = 1'b0;
      req       = '0;
   endtask

   task automatic take_response(output umi_apb_pkg::umi_pkt_t got, input int hold);
      umi_apb_pkg::umi_pkt_t seen;
      while (!resp_valid)
         advance_cycle();
      seen = resp;
      for (int i = 0; i < hold; i++) begin
         checks++;
         if (resp !== seen || req_ready) begin
            errors++;
            $display("At %0t resp moved or req_ready rose while a response was held", $time);
         end
         advance_cycle();
         if (!resp_valid) begin
            errors++;
            $display("At %0t resp_valid dropped before resp_ready", $time);
         end
      end
      got        = resp;                           // Value taken at the handshake
      resp_ready = 1'b1;
      advance_cycle();
      resp_ready = 1'b0;
   endtask

   // ########################################
   // One transaction against the model
   // ########################################
   task automatic run_access(input umi_apb_pkg::umi_opcode_e op, input logic [7:0] grp,
                             input logic [15:0] paddr, input logic [31:0] wdata, input int hold);
      umi_apb_pkg::umi_pkt_t pkt;
      umi_apb_pkg::umi_pkt_t got;
      umi_apb_pkg::umi_cmd_t exp_cmd;
      logic [31:0]           r;
      logic [31:0]           rdata;
      logic [1:0]            err;
      logic                  is_read;
      logic                  is_write;
      logic                  take;
      logic                  timeout;
      logic                  in_range;
      r            = next_random();
      pkt.cmd      = next_random();                // Random side fields
      pkt.cmd.opcode = op;
      pkt.dstaddr  = {next_random(), grp, r[7:0], paddr};
      pkt.srcaddr  = {next_random(), next_random()};
      pkt.data     = {next_random(), wdata};
      is_read  = (op == umi_apb_pkg::REQ_READ);
      is_write = (op == umi_apb_pkg::REQ_WRITE) || (op == umi_apb_pkg::REQ_POSTED);
      take     = (grp == `UMI_APB_GRPID) && (is_read || is_write);
      timeout  = (wait_w >= `UMI_APB_TIMEOUT);     // pready would land after expiry
      in_range = (paddr < `APB_NREGS * 4);
      err      = timeout ? umi_apb_pkg::UMI_ERR_TIMEOUT :
                 !in_range ? umi_apb_pkg::UMI_ERR_SLV : umi_apb_pkg::UMI_ERR_OK;
      rdata    = (is_read && !timeout && in_range) ? mirror[paddr[5:2]] : 32'd0;
      send_request(pkt);
      if (!take || op == umi_apb_pkg::REQ_POSTED) begin
         for (int i = 0; i < 3 || !req_ready; i++) begin
            if (resp_valid) begin
               errors++;
               $display("At %0t a response appeared for opcode %0d", $time, op);
            end
            advance_cycle();
         end
      end else begin
         take_response(got, hold);
         exp_cmd          = pkt.cmd;
         exp_cmd.opcode   = is_read ? umi_apb_pkg::RESP_READ : umi_apb_pkg::RESP_WRITE;
         exp_cmd.user_err = err;
         compare("resp.cmd", {32'd0, exp_cmd}, {32'd0, got.cmd});
         compare("resp.dstaddr", pkt.srcaddr, got.dstaddr);
         compare("resp.srcaddr", pkt.dstaddr, got.srcaddr);
         compare("resp.data", {32'd0, rdata}, got.data);
      end
      if (take && is_write && !timeout && in_range) begin
         mirror[paddr[5:2]] = wdata;
         if (paddr[5:2] == 4'd0)
            wait_w = wdata[3:0];                   // New wait count
      end
   endtask

   // ########################################
   // Tests
   // ########################################
   task automatic test_read_write();
      logic [31:0] r;
      for (int i = 0; i < t1_n; i++) begin
         r = next_random();
         run_access(r[0] ? umi_apb_pkg::REQ_READ : umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID,
                    {10'd0, r[5:2], 2'd0}, safe_data(r[5:2]), r[9:8]);
      end
   endtask

   task automatic test_posted();
      logic [31:0] r;
      for (int i = 0; i < t2_n; i++) begin
         r = next_random();
         run_access(umi_apb_pkg::REQ_POSTED, `UMI_APB_GRPID, {10'd0, r[5:2], 2'd0},
                    safe_data(r[5:2]), 0);
         run_access(umi_apb_pkg::REQ_READ, `UMI_APB_GRPID, {10'd0, r[5:2], 2'd0}, 32'd0, r[9:8]);
      end
   endtask

   task automatic test_out_of_range();
      logic [31:0] r;
      for (int i = 0; i < t3_n; i++) begin
         r = next_random();
         run_access(r[0] ? umi_apb_pkg::REQ_READ : umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID,
                    {r[15:6] | 10'd1, r[5:2], 2'd0}, next_random(), r[9:8]);
      end
      for (int i = 0; i < 4; i++) begin
         r = next_random();
         run_access(umi_apb_pkg::REQ_READ, `UMI_APB_GRPID, {10'd0, r[5:2], 2'd0}, 32'd0, 0);
      end
   endtask

   task automatic test_timeout();
      logic [31:0] r;
      umi_apb_pkg::umi_opcode_e op;
      r = next_random();
      run_access(umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID, 16'h0000,
                 {r[31:4], 1'b1, r[2:0]}, 0);      // W 8 to 15
      for (int i = 0; i < t4_n; i++) begin
         r  = next_random();
         op = r[1] ? umi_apb_pkg::REQ_POSTED :
              r[0] ? umi_apb_pkg::REQ_WRITE : umi_apb_pkg::REQ_READ;
         run_access(op, `UMI_APB_GRPID, {10'd0, r[5:2], 2'd0}, next_random(), r[9:8]);
      end
      for (int k = 0; k < `APB_NREGS; k++)
         compare($sformatf("regs_q[%0d]", k), {32'd0, mirror[k]},
                 {32'd0, i_dut.i_regfile.regs_q[k]});
      apply_reset();                               // Register 0 unreachable while W is high
      r = next_random();
      run_access(umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID, 16'h0000, {r[31:4], 1'b0, r[2:0]}, 0);
      for (int i = 0; i < 4; i++) begin
         r = next_random();
         run_access(r[0] ? umi_apb_pkg::REQ_READ : umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID,
                    {10'd0, r[5:2], 2'd0}, safe_data(r[5:2]), r[9:8]);
      end
   endtask

   task automatic test_dropped();
      logic [31:0] r;
      for (int i = 0; i < t5_n; i++) begin
         r = next_random();
         case (r[1:0])
            2'd0: run_access(umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID ^ {r[15:9], 1'b1},
                             {10'd0, r[5:2], 2'd0}, next_random(), 0);  // Wrong group
            2'd1: run_access(umi_apb_pkg::REQ_ATOMIC, `UMI_APB_GRPID,
                             {10'd0, r[5:2], 2'd0}, next_random(), 0);
            2'd2: run_access(umi_apb_pkg::REQ_RDMA, `UMI_APB_GRPID,
                             {10'd0, r[5:2], 2'd0}, next_random(), 0);
            default: run_access(umi_apb_pkg::INVALID, `UMI_APB_GRPID,
                                {10'd0, r[5:2], 2'd0}, next_random(), 0);
         endcase
      end
      for (int k = 0; k < `APB_NREGS; k++)
         run_access(umi_apb_pkg::REQ_READ, `UMI_APB_GRPID, 16'(k * 4), 32'd0, 0);
   endtask

   task automatic test_backpressure();
      logic [31:0] r;
      for (int i = 0; i < t6_n; i++) begin
         r = next_random();
         run_access(r[0] ? umi_apb_pkg::REQ_READ : umi_apb_pkg::REQ_WRITE, `UMI_APB_GRPID,
                    {10'd0, r[5:2], 2'd0}, safe_data(r[5:2]), 3 + r[9:8]);
      end
   endtask

   // ########################################
   // Sequence
   // ########################################
   initial begin
      nreset     = 1'b0;
      req        = '0;
      req_valid  = 1'b0;
      resp_ready = 1'b0;
      apply_reset();
      mark = errors;
      test_read_write();
      finish_test("read after write");
      test_posted();
      finish_test("posted writes");
      test_out_of_range();
      finish_test("out of range");
      test_timeout();
      finish_test("access timeout");
      test_dropped();
      finish_test("dropped requests");
      test_backpressure();
      finish_test("response back-pressure");
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: flist.f
+incdir+common
common/umi_apb_pkg.sv
umi2apb/umi2apb_decode.sv
umi2apb/umi2apb_fsm.sv
umi2apb/umi2apb_timer.sv
umi2apb/umi2apb_datapath.sv
design/apb_regfile.sv
design/umi_apb_top.sv
test/tb_umi_apb.sv

// File: Bender.yml
package:
  name: umi_apb

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/umi_apb_pkg.sv
      - umi2apb/umi2apb_decode.sv
      - umi2apb/umi2apb_fsm.sv
      - umi2apb/umi2apb_timer.sv
      - umi2apb/umi2apb_datapath.sv
      - design/apb_regfile.sv
      - design/umi_apb_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_umi_apb.sv
